//--- Makefile
TOP := tb_fpu_flag_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f list.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

lint:
	verilator --lint-only -Wall +incdir+include --top-module fpu_flag_top \
	  src/fcsr_pkg.sv src/fpu_pkg.sv src/fcsr.sv src/fpu_cmp_lane.sv \
	  src/fpu_cvt_lane.sv src/fpu_flag_top.sv

clean:
	rm -rf obj_dir sim.log

//--- include/fpu_consts.svh
// CSR addresses, Zicsr funct3 codes and widths for the FP slice; include in RTL and testbench
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// floating-point CSR addresses
`define FPU_CSR_FFLAGS_ADDR 12'h001
`define FPU_CSR_FRM_ADDR    12'h002
`define FPU_CSR_FCSR_ADDR   12'h003

// zicsr funct3 encodings
`define FPU_CSRRW_FUN3  3'b001
`define FPU_CSRRS_FUN3  3'b010
`define FPU_CSRRC_FUN3  3'b011
`define FPU_CSRRWI_FUN3 3'b101
`define FPU_CSRRSI_FUN3 3'b110
`define FPU_CSRRCI_FUN3 3'b111

// register field widths
`define FPU_FFLAGS_W   5
`define FPU_FRM_W      3
`define FPU_REG_ADDR_W 5

// quiet NaN returned when no operand is usable
`define FPU_CANON_NAN 32'h7FC00000

`endif

//--- list.f
+incdir+include
src/fcsr_pkg.sv
src/fpu_pkg.sv
src/fcsr.sv
src/fpu_cmp_lane.sv
src/fpu_cvt_lane.sv
src/fpu_flag_top.sv
testbench/tb_fpu_flag_top.sv

//--- src/fcsr.sv
// frm/fflags CSR block; executes Zicsr commands and accrues the flags of both lanes
`include "fpu_consts.svh"

module fcsr (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // zicsr command
  input  logic                       v_i,
  input  logic [2:0]                 funct3_i,
  input  logic [`FPU_REG_ADDR_W-1:0] rs1_i,
  input  fcsr_pkg::fcsr_s            data_i,
  input  logic [11:0]                addr_i,
  output fcsr_pkg::fcsr_s            data_o,
  // flag accrue from the lanes
  input  logic [1:0]                 fflags_v_i,
  input  fcsr_pkg::fflags_s [1:0]    fflags_i,
  output fcsr_pkg::frm_e             frm_o
);

  localparam int csr_w = `FPU_FRM_W + `FPU_FFLAGS_W;

  logic [`FPU_FRM_W-1:0]    frm_r;
  logic [`FPU_FFLAGS_W-1:0] fflags_r;
  logic [csr_w-1:0]         cmd_val;
  logic [csr_w-1:0]         write_mask;
  logic [csr_w-1:0]         write_data;
  logic [`FPU_FRM_W-1:0]    frm_mask;
  logic [`FPU_FRM_W-1:0]    frm_data;
  logic [`FPU_FFLAGS_W-1:0] fflags_mask;
  logic [`FPU_FFLAGS_W-1:0] fflags_data;
  logic [`FPU_FFLAGS_W-1:0] accrued;
  logic [csr_w-1:0]         rd_data;

  // funct3[2] selects the immediate forms
  assign cmd_val = funct3_i[2] ? csr_w'(rs1_i) : data_i;

  always_comb begin
    write_mask = '0;
    write_data = '0;
    if (v_i) begin
      case (funct3_i)
        `FPU_CSRRW_FUN3, `FPU_CSRRWI_FUN3: begin
          write_mask = '1;
          write_data = cmd_val;
        end
        `FPU_CSRRS_FUN3, `FPU_CSRRSI_FUN3: begin
          write_mask = cmd_val;
          write_data = '1;
        end
        `FPU_CSRRC_FUN3, `FPU_CSRRCI_FUN3: begin
          write_mask = cmd_val;
          write_data = '0;
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    accrued = '0;
    for (int i = 0; i < 2; i++) begin
      if (fflags_v_i[i]) begin
        accrued = accrued | fflags_i[i];
      end
    end
  end

  always_comb begin
    frm_mask    = '0;
    frm_data    = '0;
    fflags_mask = '0;
    fflags_data = '0;
    case (addr_i)
      `FPU_CSR_FFLAGS_ADDR: begin
        fflags_mask = write_mask[`FPU_FFLAGS_W-1:0];
        fflags_data = write_data[`FPU_FFLAGS_W-1:0];
      end
      `FPU_CSR_FRM_ADDR: begin
        frm_mask = write_mask[`FPU_FRM_W-1:0];
        frm_data = write_data[`FPU_FRM_W-1:0];
      end
      `FPU_CSR_FCSR_ADDR: begin
        fflags_mask = write_mask[`FPU_FFLAGS_W-1:0];
        fflags_data = write_data[`FPU_FFLAGS_W-1:0];
        frm_mask    = write_mask[csr_w-1:`FPU_FFLAGS_W];
        frm_data    = write_data[csr_w-1:`FPU_FFLAGS_W];
      end
      default: ;
    endcase
    // lane flags only go in when no command is present
    if (!v_i) begin
      fflags_mask = accrued;
      fflags_data = accrued;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      frm_r    <= '0;
      fflags_r <= '0;
    end else begin
      frm_r    <= (frm_r & ~frm_mask) | (frm_data & frm_mask);
      fflags_r <= (fflags_r & ~fflags_mask) | (fflags_data & fflags_mask);
    end
  end

  // old value, goes to rd
  always_comb begin
    case (addr_i)
      `FPU_CSR_FFLAGS_ADDR: rd_data = csr_w'(fflags_r);
      `FPU_CSR_FRM_ADDR:    rd_data = csr_w'(frm_r);
      `FPU_CSR_FCSR_ADDR:   rd_data = {frm_r, fflags_r};
      default:              rd_data = '0;
    endcase
  end

  assign data_o = rd_data;
  assign frm_o  = fcsr_pkg::frm_e'(frm_r);

  // the core holds CSR commands until both lanes have drained
  a_no_accrue_on_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> (fflags_v_i == 2'b00))
    else $error("fcsr: lane flags arrived together with a CSR command");

  a_legal_funct3: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> (funct3_i inside {`FPU_CSRRW_FUN3, `FPU_CSRRS_FUN3, `FPU_CSRRC_FUN3,
                              `FPU_CSRRWI_FUN3, `FPU_CSRRSI_FUN3, `FPU_CSRRCI_FUN3}))
    else $error("fcsr: unknown funct3 on a CSR command");

endmodule

//--- src/fcsr_pkg.sv
// CSR-side types for the flag and rounding-mode registers, used by RTL and testbench
`include "fpu_consts.svh"

package fcsr_pkg;

  // exception flags, nv is the msb
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_s;

  // rounding modes, 5 and 6 reserved
  typedef enum logic [`FPU_FRM_W-1:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4,
    dyn = 3'd7
  } frm_e;

  // fcsr layout, frm above fflags
  typedef struct packed {
    logic [`FPU_FRM_W-1:0] frm;
    fflags_s               fflags;
  } fcsr_s;

endpackage

//--- src/fpu_cmp_lane.sv
// two-stage compare and min/max lane; results and nv flag two cycles after issue
`include "fpu_consts.svh"

module fpu_cmp_lane (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              v_i,
  input  fpu_pkg::cmp_op_e  op_i,
  input  fpu_pkg::float_s   a_i,
  input  fpu_pkg::float_s   b_i,
  output logic              v_o,
  output logic [31:0]       result_o,
  output fcsr_pkg::fflags_s flags_o,
  output logic              busy_o
);

  logic              s1_v;
  fpu_pkg::cmp_op_e  s1_op;
  fpu_pkg::float_s   s1_a;
  fpu_pkg::float_s   s1_b;
  logic              s1_a_nan;
  logic              s1_a_snan;
  logic              s1_a_zero;
  logic              s1_b_nan;
  logic              s1_b_snan;
  logic              s1_b_zero;
  logic              any_nan;
  logic              any_snan;
  logic              both_zero;
  logic              ord_lt;
  logic              lt;
  logic              eq;
  logic [31:0]       res;
  fcsr_pkg::fflags_s flags;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v <= 1'b0;
      v_o  <= 1'b0;
    end else begin
      s1_v <= v_i;
      v_o  <= s1_v;
    end
  end

  // stage 1: operands plus classification
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      s1_op     <= op_i;
      s1_a      <= a_i;
      s1_b      <= b_i;
      s1_a_nan  <= (a_i.exponent == 8'hff) && (a_i.mantissa != '0);
      s1_a_snan <= (a_i.exponent == 8'hff) && (a_i.mantissa != '0) && !a_i.mantissa[22];
      s1_a_zero <= (a_i.exponent == 8'h00) && (a_i.mantissa == '0);
      s1_b_nan  <= (b_i.exponent == 8'hff) && (b_i.mantissa != '0);
      s1_b_snan <= (b_i.exponent == 8'hff) && (b_i.mantissa != '0) && !b_i.mantissa[22];
      s1_b_zero <= (b_i.exponent == 8'h00) && (b_i.mantissa == '0);
    end
  end

  always_comb begin
    any_nan   = s1_a_nan | s1_b_nan;
    any_snan  = s1_a_snan | s1_b_snan;
    both_zero = s1_a_zero & s1_b_zero;
    // sign-magnitude order, -0 sits below +0
    if (s1_a.sign != s1_b.sign) begin
      ord_lt = s1_a.sign;
    end else if (s1_a.sign) begin
      ord_lt = {s1_a.exponent, s1_a.mantissa} > {s1_b.exponent, s1_b.mantissa};
    end else begin
      ord_lt = {s1_a.exponent, s1_a.mantissa} < {s1_b.exponent, s1_b.mantissa};
    end
    // the relational ops treat the two zeros as equal
    eq    = (s1_a == s1_b) | both_zero;
    lt    = ord_lt & !both_zero;
    res   = '0;
    flags = '0;
    case (s1_op)
      fpu_pkg::feq: begin
        res[0]   = !any_nan & eq;
        flags.nv = any_snan;
      end
      fpu_pkg::flt: begin
        res[0]   = !any_nan & lt;
        flags.nv = any_nan;
      end
      fpu_pkg::fle: begin
        res[0]   = !any_nan & (lt | eq);
        flags.nv = any_nan;
      end
      fpu_pkg::fmin, fpu_pkg::fmax: begin
        flags.nv = any_snan;
        if (s1_a_nan && s1_b_nan) begin
          res = `FPU_CANON_NAN;
        end else if (s1_a_nan) begin
          res = s1_b;
        end else if (s1_b_nan) begin
          res = s1_a;
        end else if (s1_op == fpu_pkg::fmin) begin
          res = ord_lt ? s1_a : s1_b;
        end else begin
          res = ord_lt ? s1_b : s1_a;
        end
      end
      default: ;
    endcase
  end

  // stage 2 output registers
  always_ff @(posedge clk_i) begin
    if (s1_v) begin
      result_o <= res;
      flags_o  <= flags;
    end
  end

  assign busy_o = s1_v | v_o;

  a_cmp_op_defined: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> (op_i inside {fpu_pkg::feq, fpu_pkg::flt, fpu_pkg::fle,
                          fpu_pkg::fmin, fpu_pkg::fmax}))
    else $error("fpu_cmp_lane: undefined compare opcode issued");

endmodule

//--- src/fpu_cvt_lane.sv
// two-stage float to int32/uint32 conversion lane with rounding and saturation

module fpu_cvt_lane (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              v_i,
  input  fpu_pkg::cvt_op_e  op_i,
  input  fcsr_pkg::frm_e    rm_i,
  input  fcsr_pkg::frm_e    frm_i,
  input  fpu_pkg::float_s   a_i,
  output logic              v_o,
  output logic [31:0]       result_o,
  output fcsr_pkg::fflags_s flags_o,
  output logic              busy_o
);

  fcsr_pkg::frm_e    rm_pick;
  fcsr_pkg::frm_e    rm_eff;
  logic              a_nan;
  logic              a_huge;
  logic [5:0]        shamt;
  logic [63:0]       fixed;
  logic              s1_v;
  fpu_pkg::cvt_op_e  s1_op;
  fcsr_pkg::frm_e    s1_rm;
  logic              s1_sign;
  logic              s1_nan;
  logic              s1_huge;
  logic [31:0]       s1_int;
  logic              s1_guard;
  logic              s1_sticky;
  logic              inexact;
  logic              inc;
  logic [32:0]       mag;
  logic              range_err;
  logic [31:0]       max_val;
  logic [31:0]       min_val;
  logic [31:0]       res;
  fcsr_pkg::fflags_s flags;

  // dynamic mode comes from frm, reserved encodings run as rne
  always_comb begin
    rm_pick = (rm_i == fcsr_pkg::dyn) ? frm_i : rm_i;
    case (rm_pick)
      fcsr_pkg::rtz, fcsr_pkg::rdn, fcsr_pkg::rup, fcsr_pkg::rmm: rm_eff = rm_pick;
      default: rm_eff = fcsr_pkg::rne;
    endcase
  end

  // fixed point with 32 integer and 32 fraction bits
  always_comb begin
    a_nan  = (a_i.exponent == 8'hff) && (a_i.mantissa != '0);
    a_huge = a_i.exponent >= 8'd159;
    shamt  = 6'(a_i.exponent - 8'd118);
    fixed  = '0;
    if (a_i.exponent >= 8'd126 && !a_huge) begin
      fixed = 64'({1'b1, a_i.mantissa}) << shamt;
    end else begin
      // below one half, only sticky survives
      fixed[0] = (a_i.exponent != 8'd0) || (a_i.mantissa != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v <= 1'b0;
      v_o  <= 1'b0;
    end else begin
      s1_v <= v_i;
      v_o  <= s1_v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      s1_op     <= op_i;
      s1_rm     <= rm_eff;
      s1_sign   <= a_i.sign;
      s1_nan    <= a_nan;
      s1_huge   <= a_huge;
      s1_int    <= fixed[63:32];
      s1_guard  <= fixed[31];
      s1_sticky <= |fixed[30:0];
    end
  end

  // stage 2: round, range check, saturate
  always_comb begin
    inexact = s1_guard | s1_sticky;
    case (s1_rm)
      fcsr_pkg::rtz: inc = 1'b0;
      fcsr_pkg::rdn: inc = s1_sign & inexact;
      fcsr_pkg::rup: inc = !s1_sign & inexact;
      fcsr_pkg::rmm: inc = s1_guard;
      default:       inc = s1_guard & (s1_sticky | s1_int[0]);
    endcase
    mag = {1'b0, s1_int} + 33'(inc);
    if (s1_op == fpu_pkg::cvt_w) begin
      max_val   = 32'h7fff_ffff;
      min_val   = 32'h8000_0000;
      range_err = s1_huge | (s1_sign ? (mag > 33'h0_8000_0000) : (mag > 33'h0_7fff_ffff));
    end else begin
      max_val   = 32'hffff_ffff;
      min_val   = 32'h0000_0000;
      range_err = s1_huge | (s1_sign ? (mag != '0) : mag[32]);
    end
    flags    = '0;
    flags.nv = s1_nan | range_err;
    if (s1_nan) begin
      res = max_val;
    end else if (range_err) begin
      res = s1_sign ? min_val : max_val;
    end else begin
      res      = s1_sign ? (~mag[31:0] + 32'd1) : mag[31:0];
      flags.nx = inexact;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_v) begin
      result_o <= res;
      flags_o  <= flags;
    end
  end

  assign busy_o = s1_v | v_o;

endmodule

//--- src/fpu_flag_top.sv
// FP execution slice top; compare and convert lanes feeding the frm/fflags CSR block
`include "fpu_consts.svh"

module fpu_flag_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // csr command
  input  logic                       csr_v_i,
  input  logic [2:0]                 csr_funct3_i,
  input  logic [`FPU_REG_ADDR_W-1:0] csr_rs1_i,
  input  fcsr_pkg::fcsr_s            csr_data_i,
  input  logic [11:0]                csr_addr_i,
  output fcsr_pkg::fcsr_s            csr_data_o,
  // compare issue
  input  logic                       cmp_v_i,
  input  fpu_pkg::cmp_op_e           cmp_op_i,
  input  fpu_pkg::float_s            cmp_a_i,
  input  fpu_pkg::float_s            cmp_b_i,
  // convert issue
  input  logic                       cvt_v_i,
  input  fpu_pkg::cvt_op_e           cvt_op_i,
  input  fcsr_pkg::frm_e             cvt_rm_i,
  input  fpu_pkg::float_s            cvt_a_i,
  // results
  output logic                       cmp_v_o,
  output logic [31:0]                cmp_result_o,
  output logic                       cvt_v_o,
  output logic [31:0]                cvt_result_o,
  output fcsr_pkg::frm_e             frm_o,
  output logic                       fpu_busy_o
);

  fcsr_pkg::fflags_s cmp_flags;
  fcsr_pkg::fflags_s cvt_flags;
  logic              cmp_busy;
  logic              cvt_busy;

  fpu_cmp_lane i_cmp (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (cmp_v_i),
    .op_i     (cmp_op_i),
    .a_i      (cmp_a_i),
    .b_i      (cmp_b_i),
    .v_o      (cmp_v_o),
    .result_o (cmp_result_o),
    .flags_o  (cmp_flags),
    .busy_o   (cmp_busy)
  );

  // dynamic rounding reads frm straight from the CSR block
  fpu_cvt_lane i_cvt (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (cvt_v_i),
    .op_i     (cvt_op_i),
    .rm_i     (cvt_rm_i),
    .frm_i    (frm_o),
    .a_i      (cvt_a_i),
    .v_o      (cvt_v_o),
    .result_o (cvt_result_o),
    .flags_o  (cvt_flags),
    .busy_o   (cvt_busy)
  );

  fcsr i_fcsr (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .v_i        (csr_v_i),
    .funct3_i   (csr_funct3_i),
    .rs1_i      (csr_rs1_i),
    .data_i     (csr_data_i),
    .addr_i     (csr_addr_i),
    .data_o     (csr_data_o),
    .fflags_v_i ({cvt_v_o, cmp_v_o}),
    .fflags_i   ({cvt_flags, cmp_flags}),
    .frm_o      (frm_o)
  );

  assign fpu_busy_o = cmp_busy | cvt_busy;

endmodule

//--- src/fpu_pkg.sv
// execution-side types for the compare and convert lanes, used by RTL and testbench

package fpu_pkg;

  // compare lane operations
  typedef enum logic [2:0] {
    feq  = 3'd0,
    flt  = 3'd1,
    fle  = 3'd2,
    fmin = 3'd3,
    fmax = 3'd4
  } cmp_op_e;

  // float to int targets
  typedef enum logic {
    cvt_w  = 1'b0,
    cvt_wu = 1'b1
  } cvt_op_e;

  // single-precision fields
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } float_s;

endpackage

//--- testbench/tb_fpu_flag_top.sv
// self-checking testbench for fpu_flag_top; compile with list.f, the run prints its verdict last
`include "fpu_consts.svh"

module tb_fpu_flag_top;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    fcsr_pkg::fflags_s flags;
    logic [31:0]       value;
  } expect_s;

  localparam int n_spec     = 24;
  localparam int n_csr_rep  = 4;
  localparam int n_cmp_rand = 500;
  localparam int n_cvt_rand = 500;
  localparam int n_dyn      = 24;
  localparam int n_acc      = 64;
  localparam int total_items = n_csr_rep * 36 + 4 + 5 * n_spec * n_spec + 5 + n_cmp_rand + 1
                               + 20 * n_spec + n_cvt_rand + 1 + 7 * (n_dyn + 3) + n_acc + 4;
  localparam int watchdog_cycles = total_items * 20 + 1000;

  // zeros, infinities, NaNs, halves and values near the 2^31 and 2^32 limits
  localparam logic [31:0] spec [n_spec] = '{
    32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
    32'h7fc0_0000, 32'h7fa0_0000, 32'hffc0_0001, 32'hff80_0001,
    32'h3f00_0000, 32'hbf00_0000, 32'h3fc0_0000, 32'hbfc0_0000,
    32'h4020_0000, 32'hc020_0000, 32'h4eff_ffff, 32'h4f00_0000,
    32'hcf00_0000, 32'hcf00_0001, 32'h4f7f_ffff, 32'h4f80_0000,
    32'h0000_0001, 32'h3f80_0000, 32'hbf80_0000, 32'h3eff_ffff
  };

  logic                       clk_i;
  logic                       reset_i;
  logic                       csr_v_i;
  logic [2:0]                 csr_funct3_i;
  logic [`FPU_REG_ADDR_W-1:0] csr_rs1_i;
  fcsr_pkg::fcsr_s            csr_data_i;
  logic [11:0]                csr_addr_i;
  fcsr_pkg::fcsr_s            csr_data_o;
  logic                       cmp_v_i;
  fpu_pkg::cmp_op_e           cmp_op_i;
  fpu_pkg::float_s            cmp_a_i;
  fpu_pkg::float_s            cmp_b_i;
  logic                       cvt_v_i;
  fpu_pkg::cvt_op_e           cvt_op_i;
  fcsr_pkg::frm_e             cvt_rm_i;
  fpu_pkg::float_s            cvt_a_i;
  logic                       cmp_v_o;
  logic [31:0]                cmp_result_o;
  logic                       cvt_v_o;
  logic [31:0]                cvt_result_o;
  fcsr_pkg::frm_e             frm_o;
  logic                       fpu_busy_o;

  // shadow of the CSR block
  logic [`FPU_FRM_W-1:0]    frm_m;
  logic [`FPU_FFLAGS_W-1:0] fflags_m;

  expect_s cmp_exp_q [$];
  int      cmp_edge_q [$];
  expect_s cvt_exp_q [$];
  int      cvt_edge_q [$];
  int      edge_cnt  = 0;
  int      fail_cnt  = 0;
  int      other_cnt = 0;

  fpu_flag_top i_dut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .csr_v_i      (csr_v_i),
    .csr_funct3_i (csr_funct3_i),
    .csr_rs1_i    (csr_rs1_i),
    .csr_data_i   (csr_data_i),
    .csr_addr_i   (csr_addr_i),
    .csr_data_o   (csr_data_o),
    .cmp_v_i      (cmp_v_i),
    .cmp_op_i     (cmp_op_i),
    .cmp_a_i      (cmp_a_i),
    .cmp_b_i      (cmp_b_i),
    .cvt_v_i      (cvt_v_i),
    .cvt_op_i     (cvt_op_i),
    .cvt_rm_i     (cvt_rm_i),
    .cvt_a_i      (cvt_a_i),
    .cmp_v_o      (cmp_v_o),
    .cmp_result_o (cmp_result_o),
    .cvt_v_o      (cvt_v_o),
    .cvt_result_o (cvt_result_o),
    .frm_o        (frm_o),
    .fpu_busy_o   (fpu_busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) edge_cnt <= edge_cnt + 1;

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
      fail_cnt++;
    end
  endtask

  // ordering key: unsigned compare of keys gives float order, -0 below +0
  function automatic logic [31:0] order_key(logic [31:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
  endfunction

  function automatic expect_s ref_cmp(fpu_pkg::cmp_op_e op, logic [31:0] a, logic [31:0] b);
    expect_s r;
    logic    a_nan;
    logic    b_nan;
    logic    any_snan;
    logic    zeros;
    logic    less;
    a_nan    = (a[30:23] == 8'hff) && (a[22:0] != 0);
    b_nan    = (b[30:23] == 8'hff) && (b[22:0] != 0);
    any_snan = (a_nan && !a[22]) || (b_nan && !b[22]);
    zeros    = (a[30:0] == 0) && (b[30:0] == 0);
    less     = order_key(a) < order_key(b);
    r = '0;
    case (op)
      fpu_pkg::feq: begin
        r.value[0] = !(a_nan || b_nan) && (a == b || zeros);
        r.flags.nv = any_snan;
      end
      fpu_pkg::flt: begin
        r.value[0] = !(a_nan || b_nan) && less && !zeros;
        r.flags.nv = a_nan || b_nan;
      end
      fpu_pkg::fle: begin
        r.value[0] = !(a_nan || b_nan) && (less || a == b || zeros);
        r.flags.nv = a_nan || b_nan;
      end
      default: begin
        r.flags.nv = any_snan;
        if (a_nan && b_nan) r.value = `FPU_CANON_NAN;
        else if (a_nan) r.value = b;
        else if (b_nan) r.value = a;
        else if (op == fpu_pkg::fmin) r.value = less ? a : b;
        else r.value = less ? b : a;
      end
    endcase
    return r;
  endfunction

  function automatic fcsr_pkg::frm_e resolve_rm(fcsr_pkg::frm_e rm);
    logic [2:0] pick;
    pick = (rm == fcsr_pkg::dyn) ? frm_m : rm;
    return (pick > 3'd4) ? fcsr_pkg::rne : fcsr_pkg::frm_e'(pick);
  endfunction

  // value = sig * 2^(e-150); split into integer and remainder, compare remainder with one half
  function automatic expect_s ref_cvt(fpu_pkg::cvt_op_e op, fcsr_pkg::frm_e rm, logic [31:0] a);
    expect_s     r;
    logic        sign;
    int          e;
    logic [63:0] sig;
    logic [63:0] mag;
    logic [63:0] rem;
    logic [63:0] half;
    logic        up;
    logic        bad;
    sign = a[31];
    e    = int'(a[30:23]);
    sig  = {40'd0, (e != 0), a[22:0]};
    r    = '0;
    if (e >= 150) begin
      mag  = (e > 189) ? 64'd0 : sig << (e - 150);
      rem  = 0;
      half = 1;
    end else if (e < 90) begin
      mag  = 0;
      rem  = 64'(sig != 0);
      half = 2;
    end else begin
      mag  = sig >> (150 - e);
      rem  = sig & ((64'd1 << (150 - e)) - 1);
      half = 64'd1 << (149 - e);
    end
    case (rm)
      fcsr_pkg::rtz: up = 1'b0;
      fcsr_pkg::rdn: up = sign && (rem != 0);
      fcsr_pkg::rup: up = !sign && (rem != 0);
      fcsr_pkg::rmm: up = rem >= half;
      default:       up = (rem > half) || ((rem == half) && mag[0]);
    endcase
    mag = mag + 64'(up);
    if (e == 255 && a[22:0] != 0) begin
      r.value    = (op == fpu_pkg::cvt_w) ? 32'h7fff_ffff : 32'hffff_ffff;
      r.flags.nv = 1'b1;
      return r;
    end
    if (op == fpu_pkg::cvt_w) begin
      bad = (e > 189) || (sign ? (mag > 64'h8000_0000) : (mag > 64'h7fff_ffff));
      r.value = sign ? 32'h8000_0000 : 32'h7fff_ffff;
    end else begin
      bad = (e > 189) || (sign ? (mag != 0) : (mag > 64'hffff_ffff));
      r.value = sign ? 32'h0 : 32'hffff_ffff;
    end
    r.flags.nv = bad;
    if (!bad) begin
      r.value    = sign ? 32'(64'd0 - mag) : mag[31:0];
      r.flags.nx = rem != 0;
    end
    return r;
  endfunction

  function automatic logic [7:0] shadow_read(logic [11:0] addr);
    case (addr)
      `FPU_CSR_FFLAGS_ADDR: return {3'b0, fflags_m};
      `FPU_CSR_FRM_ADDR:    return {5'b0, frm_m};
      `FPU_CSR_FCSR_ADDR:   return {frm_m, fflags_m};
      default:              return 8'h00;
    endcase
  endfunction

  function automatic void shadow_apply(logic [2:0] f3, logic [4:0] rs1, logic [7:0] data,
                                       logic [11:0] addr);
    logic [7:0] val;
    logic [7:0] cur;
    logic [7:0] nxt;
    val = f3[2] ? {3'b0, rs1} : data;
    cur = shadow_read(addr);
    case (f3[1:0])
      2'b01:   nxt = val;
      2'b10:   nxt = cur | val;
      default: nxt = cur & ~val;
    endcase
    if (addr == `FPU_CSR_FFLAGS_ADDR || addr == `FPU_CSR_FCSR_ADDR) fflags_m = nxt[4:0];
    if (addr == `FPU_CSR_FRM_ADDR) frm_m = nxt[2:0];
    if (addr == `FPU_CSR_FCSR_ADDR) frm_m = nxt[7:5];
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #1;
    cmp_v_i = 1'b0;
    cvt_v_i = 1'b0;
    csr_v_i = 1'b0;
  endtask

  // one command, old value checked before the capturing edge
  task automatic csr_cmd(input logic [2:0] f3, input logic [4:0] rs1, input logic [7:0] data,
                         input logic [11:0] addr);
    logic [7:0] old;
    tick();
    old          = shadow_read(addr);
    csr_v_i      = 1'b1;
    csr_funct3_i = f3;
    csr_rs1_i    = rs1;
    csr_data_i   = data;
    csr_addr_i   = addr;
    @(negedge clk_i);
    check_value($sformatf("csr old value at %h", addr), 32'(csr_data_o), 32'(old));
    shadow_apply(f3, rs1, data, addr);
    tick();
  endtask

  task automatic issue_cmp(input fpu_pkg::cmp_op_e op, input logic [31:0] a, input logic [31:0] b);
    expect_s e;
    e        = ref_cmp(op, a, b);
    cmp_v_i  = 1'b1;
    cmp_op_i = op;
    cmp_a_i  = a;
    cmp_b_i  = b;
    cmp_exp_q.push_back(e);
    cmp_edge_q.push_back(edge_cnt + 1);
    fflags_m = fflags_m | e.flags;
  endtask

  task automatic issue_cvt(input fpu_pkg::cvt_op_e op, input fcsr_pkg::frm_e rm,
                           input logic [31:0] a);
    expect_s e;
    e        = ref_cvt(op, resolve_rm(rm), a);
    cvt_v_i  = 1'b1;
    cvt_op_i = op;
    cvt_rm_i = rm;
    cvt_a_i  = a;
    cvt_exp_q.push_back(e);
    cvt_edge_q.push_back(edge_cnt + 1);
    fflags_m = fflags_m | e.flags;
  endtask

  task automatic wait_idle();
    tick();
    @(negedge clk_i);
    while (fpu_busy_o) @(negedge clk_i);
  endtask

  // csrrci returns the accrued flags and clears them
  task automatic probe_flags();
    wait_idle();
    csr_cmd(`FPU_CSRRCI_FUN3, 5'h1f, 8'h00, `FPU_CSR_FFLAGS_ADDR);
  endtask

  function automatic logic [31:0] pick_operand();
    if ($urandom_range(2, 0) == 0) return spec[$urandom_range(n_spec - 1, 0)];
    return $urandom;
  endfunction

  // mix of specials, ties or exact values, and general values near the integer range
  function automatic logic [31:0] cvt_operand();
    int          e;
    logic [22:0] m;
    if ($urandom_range(3, 0) == 0) return spec[$urandom_range(n_spec - 1, 0)];
    if ($urandom_range(2, 0) == 0) begin
      e = int'($urandom_range(149, 127));
      m = 23'($urandom) & ~23'((32'd1 << (149 - e)) - 1);
      return {1'($urandom), 8'(e), m};
    end
    return {1'($urandom), 8'($urandom_range(162, 118)), 23'($urandom)};
  endfunction

  function automatic fpu_pkg::cmp_op_e rand_cmp_op();
    return fpu_pkg::cmp_op_e'(3'($urandom_range(4, 0)));
  endfunction

  function automatic fcsr_pkg::frm_e rand_static_rm();
    return fcsr_pkg::frm_e'(3'($urandom_range(6, 0)));
  endfunction

  task automatic csr_sweep();
    logic [2:0] f3_list [6] = '{`FPU_CSRRW_FUN3, `FPU_CSRRS_FUN3, `FPU_CSRRC_FUN3,
                                `FPU_CSRRWI_FUN3, `FPU_CSRRSI_FUN3, `FPU_CSRRCI_FUN3};
    for (int rep = 0; rep < n_csr_rep; rep++) begin
      for (int i = 0; i < 6; i++) begin
        for (int j = 1; j <= 3; j++) begin
          csr_cmd(f3_list[i], 5'($urandom), 8'($urandom), 12'(j));
          csr_cmd(`FPU_CSRRS_FUN3, 5'd0, 8'd0, 12'(j));
        end
      end
    end
    // unknown address reads zero and leaves fcsr alone
    csr_cmd(`FPU_CSRRW_FUN3, 5'h1f, 8'hff, 12'h7c0);
    csr_cmd(`FPU_CSRRS_FUN3, 5'd0, 8'd0, `FPU_CSR_FCSR_ADDR);
    csr_cmd(`FPU_CSRRW_FUN3, 5'd0, 8'd0, `FPU_CSR_FCSR_ADDR);
  endtask

  task automatic cmp_sweep();
    for (int op = 0; op < 5; op++) begin
      for (int i = 0; i < n_spec; i++) begin
        for (int j = 0; j < n_spec; j++) begin
          tick();
          issue_cmp(fpu_pkg::cmp_op_e'(3'(op)), spec[i], spec[j]);
        end
      end
      probe_flags();
    end
    for (int k = 0; k < n_cmp_rand; k++) begin
      logic [31:0] a;
      a = pick_operand();
      tick();
      issue_cmp(rand_cmp_op(), a, ($urandom_range(7, 0) == 0) ? a : pick_operand());
    end
    probe_flags();
  endtask

  task automatic cvt_sweep();
    // flags probed after every special value
    for (int m = 0; m < 5; m++) begin
      for (int op = 0; op < 2; op++) begin
        for (int i = 0; i < n_spec; i++) begin
          tick();
          issue_cvt(fpu_pkg::cvt_op_e'(1'(op)), fcsr_pkg::frm_e'(3'(m)), spec[i]);
          probe_flags();
        end
      end
    end
    for (int k = 0; k < n_cvt_rand; k++) begin
      tick();
      issue_cvt(fpu_pkg::cvt_op_e'(1'($urandom)), rand_static_rm(), cvt_operand());
    end
    probe_flags();
  endtask

  // modes 5 and 6 in frm must act as rne
  task automatic dyn_round_test();
    for (int m = 0; m < 7; m++) begin
      csr_cmd(`FPU_CSRRWI_FUN3, 5'(m), 8'd0, `FPU_CSR_FRM_ADDR);
      check_value("frm_o after write", 32'(frm_o), 32'(m));
      for (int k = 0; k < n_dyn; k++) begin
        tick();
        issue_cvt(fpu_pkg::cvt_op_e'(1'($urandom)), fcsr_pkg::dyn, cvt_operand());
      end
      probe_flags();
    end
    csr_cmd(`FPU_CSRRWI_FUN3, 5'd0, 8'd0, `FPU_CSR_FRM_ADDR);
  endtask

  task automatic accrue_test();
    csr_cmd(`FPU_CSRRW_FUN3, 5'd0, 8'd0, `FPU_CSR_FFLAGS_ADDR);
    for (int k = 0; k < n_acc; k++) begin
      tick();
      issue_cmp(rand_cmp_op(), pick_operand(), pick_operand());
      issue_cvt(fpu_pkg::cvt_op_e'(1'($urandom)), rand_static_rm(), cvt_operand());
    end
    wait_idle();
    csr_cmd(`FPU_CSRRS_FUN3, 5'd0, 8'd0, `FPU_CSR_FFLAGS_ADDR);
    csr_cmd(`FPU_CSRRCI_FUN3, 5'h1f, 8'd0, `FPU_CSR_FFLAGS_ADDR);
    csr_cmd(`FPU_CSRRS_FUN3, 5'd0, 8'd0, `FPU_CSR_FFLAGS_ADDR);
  endtask

  // outputs sampled on the falling edge; the result is taken at the next rising edge
  always @(negedge clk_i) begin : compare_outputs
    expect_s exp_r;
    int      at_edge;
    if (!reset_i && cmp_v_o) begin
      if (cmp_exp_q.size() == 0) begin
        $display("ERROR at %0t: compare lane returned a result that was never issued", $time);
        other_cnt++;
      end else begin
        exp_r   = cmp_exp_q.pop_front();
        at_edge = cmp_edge_q.pop_front();
        check_value("compare latency", 32'(edge_cnt + 1), 32'(at_edge + 2));
        check_value("compare result", cmp_result_o, exp_r.value);
      end
    end
    if (!reset_i && cvt_v_o) begin
      if (cvt_exp_q.size() == 0) begin
        $display("ERROR at %0t: convert lane returned a result that was never issued", $time);
        other_cnt++;
      end else begin
        exp_r   = cvt_exp_q.pop_front();
        at_edge = cvt_edge_q.pop_front();
        check_value("convert latency", 32'(edge_cnt + 1), 32'(at_edge + 2));
        check_value("convert result", cvt_result_o, exp_r.value);
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles, the test did not finish",
             watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    void'($urandom(81321));
    reset_i      = 1'b1;
    csr_v_i      = 1'b0;
    csr_funct3_i = `FPU_CSRRS_FUN3;
    csr_rs1_i    = '0;
    csr_data_i   = '0;
    csr_addr_i   = '0;
    cmp_v_i      = 1'b0;
    cmp_op_i     = fpu_pkg::feq;
    cmp_a_i      = '0;
    cmp_b_i      = '0;
    cvt_v_i      = 1'b0;
    cvt_op_i     = fpu_pkg::cvt_w;
    cvt_rm_i     = fcsr_pkg::rne;
    cvt_a_i      = '0;
    frm_m        = '0;
    fflags_m     = '0;
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("frm_o after reset", 32'(frm_o), 32'd0);
    check_value("cmp_v_o after reset", 32'(cmp_v_o), 32'd0);
    check_value("cvt_v_o after reset", 32'(cvt_v_o), 32'd0);
    check_value("fpu_busy_o after reset", 32'(fpu_busy_o), 32'd0);
    csr_sweep();
    cmp_sweep();
    cvt_sweep();
    dyn_round_test();
    accrue_test();
    wait_idle();
    if (cmp_exp_q.size() != 0 || cvt_exp_q.size() != 0) begin
      $display("ERROR: %0d compare and %0d convert results never came back",
               cmp_exp_q.size(), cvt_exp_q.size());
      other_cnt++;
    end
    $display("run finished with %0d value mismatches and %0d other errors", fail_cnt, other_cnt);
    if (fail_cnt == 0 && other_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
